//--- verilog/qcpu_pkg.sv
`default_nettype none

package qcpu_pkg;

	localparam int data_w     = 8;
	localparam int addr_w     = 14;
	localparam int ram_addr_w = 6;
	localparam int reg_sel_w  = 4;

	typedef logic [data_w-1:0]     data_t;
	typedef logic [addr_w-1:0]     pc_t;
	typedef logic [ram_addr_w-1:0] ram_addr_t;
	typedef logic [reg_sel_w-1:0]  reg_sel_t;

	// Opcode 15 of this field marks an EXT instruction
	typedef enum logic [3:0] {
		alu_add, alu_adc, alu_sub, alu_sbc, alu_and, alu_or, alu_xor, alu_not,
		alu_addi, alu_adci, alu_subi, alu_sbci, alu_link, alu_jmpi, alu_cmp
	} alu_op_e;

	typedef enum logic [3:0] {
		ext_shr = 4'd0, ext_shrc = 4'd1, ext_shl = 4'd2, ext_shlc = 4'd3,
		ext_ror = 4'd4, ext_rol = 4'd5, ext_ioaddr = 4'd6, ext_iow = 4'd7,
		ext_ior = 4'd8, ext_cmpi = 4'd9, ext_reti = 4'd11, ext_mul = 4'd12,
		ext_getf = 4'd13, ext_setf = 4'd14
	} ext_op_e;

	typedef enum logic [1:0] {
		cyc_fetch, cyc_decode, cyc_execute, cyc_int
	} cycle_e;

	localparam data_t io_porta_ddr = 8'd0;
	localparam data_t io_porta     = 8'd1;
	localparam data_t io_portb_ddr = 8'd2;
	localparam data_t io_portb     = 8'd3;
	localparam data_t io_pina      = 8'd4;
	localparam data_t io_pinb      = 8'd5;

	localparam pc_t int_vector = 14'd1;

	typedef union packed {
		struct packed {
			logic [3:0] prefix; // 0100
			reg_sel_t   rd;
			data_t      value;
		} immediate;
		struct packed {
			logic [3:0] prefix; // 0101
			alu_op_e    op;
			reg_sel_t   r1;
			reg_sel_t   r2;     // Or 4-bit immediate
		} regreg;
		struct packed {
			logic [2:0]  prefix; // 011
			logic [1:0]  cond;
			logic [10:0] offset;
		} branch;
		struct packed {
			logic [1:0] prefix; // 00
			pc_t        target;
		} jump;
		struct packed {
			logic [1:0] prefix; // 10 store, 11 load
			ram_addr_t  base;
			reg_sel_t   rd;
			reg_sel_t   idx;
		} loadstore;
		struct packed {
			logic [7:0] prefix; // 0101_1111
			ext_op_e    op;
			reg_sel_t   rs;
		} ext;
	} instr_t;

	function automatic logic is_ext(instr_t i);
		return i.ext.prefix == 8'h5f;
	endfunction

	function automatic logic is_regreg(instr_t i);
		return i.regreg.prefix == 4'b0101 && !is_ext(i);
	endfunction

	function automatic logic is_imm(instr_t i);
		return i.immediate.prefix == 4'b0100;
	endfunction

	function automatic logic is_load(instr_t i);
		return i.loadstore.prefix == 2'b11;
	endfunction

endpackage

`default_nettype wire

//--- verilog/qcpu_sequencer.sv
`default_nettype none

module qcpu_sequencer (
	input  logic             clk,
	input  logic             rst_n,
	input  logic             intb,
	input  qcpu_pkg::instr_t rom_data,
	input  logic             c_next,
	input  logic             z_next,
	input  logic             flag_we,
	input  logic [15:0]      pair_data,
	output qcpu_pkg::pc_t    rom_addr,
	output qcpu_pkg::instr_t instr,
	output qcpu_pkg::cycle_e state,
	output logic             c_flag,
	output logic             z_flag,
	output logic             reg_we,
	output logic             pair_we,
	output logic             ram_we,
	output qcpu_pkg::pc_t    link_pc,
	output logic             int_entry,
	output logic             int_return
);
	import qcpu_pkg::*;

	pc_t        pc;
	pc_t        pc_next;
	pc_t        saved_pc;
	logic       ie;
	logic [2:0] saved_flags; // IE, Z, C
	logic       intb_q;
	logic       int_pending;
	logic       execute;
	logic       taken;
	logic       is_reti;
	logic       rr_writes;
	logic       ext_writes;

	assign rom_addr   = pc;
	assign link_pc    = pc + 14'd2; // Skips the jump indirect that follows link
	assign execute    = state == cyc_execute;
	assign is_reti    = is_ext(instr) && instr.ext.op == ext_reti;
	assign int_entry  = state == cyc_int;
	assign int_return = execute && is_reti;

	always_comb begin
		case (instr.branch.cond)
			2'd0: taken = !c_flag;
			2'd1: taken = c_flag;
			2'd2: taken = !z_flag;
			default: taken = z_flag;
		endcase
	end

	always_comb begin
		pc_next = pc + 14'd1;
		if (instr.jump.prefix == 2'b00)
			pc_next = instr.jump.target;
		else if (instr.branch.prefix == 3'b011 && taken)
			pc_next = pc + {{3{instr.branch.offset[10]}}, instr.branch.offset};
		else if (is_regreg(instr) && instr.regreg.op == alu_jmpi)
			pc_next = pair_data[13:0]; // R2:R1
		else if (is_reti)
			pc_next = saved_pc;
	end

	assign rr_writes = is_regreg(instr) && !(instr.regreg.op inside {alu_link, alu_jmpi, alu_cmp});
	assign ext_writes = is_ext(instr) && (instr.ext.op inside
		{ext_shr, ext_shrc, ext_shl, ext_shlc, ext_ror, ext_rol, ext_ior, ext_getf});

	assign reg_we  = execute && (is_imm(instr) || is_load(instr) || rr_writes || ext_writes);
	assign pair_we = execute && ((is_regreg(instr) && instr.regreg.op == alu_link) ||
		(is_ext(instr) && instr.ext.op == ext_mul));
	assign ram_we  = execute && instr.loadstore.prefix == 2'b10;

	always_ff @(posedge clk) begin
		if (state == cyc_decode)
			instr <= rom_data;
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state       <= cyc_fetch;
			pc          <= '0;
			c_flag      <= 1'b0;
			z_flag      <= 1'b0;
			ie          <= 1'b0;
			saved_pc    <= '0;
			saved_flags <= '0;
			intb_q      <= 1'b1;
			int_pending <= 1'b0;
		end else begin
			intb_q <= intb;
			if (!intb && intb_q)
				int_pending <= 1'b1; // Falling edge
			else if (state == cyc_fetch)
				int_pending <= 1'b0;

			case (state)
				cyc_fetch: state <= (int_pending && ie) ? cyc_int : cyc_decode;
				cyc_decode: state <= cyc_execute;
				cyc_execute: begin
					pc <= pc_next;
					if (is_reti) begin
						{ie, z_flag, c_flag} <= saved_flags;
					end else if (is_ext(instr) && instr.ext.op == ext_setf) begin
						{ie, z_flag, c_flag} <= pair_data[2:0]; // Taken from R1
					end else if (flag_we) begin
						c_flag <= c_next;
						z_flag <= z_next;
					end
					state <= cyc_fetch;
				end
				default: begin
					saved_pc    <= pc;
					saved_flags <= {ie, z_flag, c_flag};
					ie          <= 1'b0;
					pc          <= int_vector;
					state       <= cyc_fetch;
				end
			endcase
		end
	end

endmodule

`default_nettype wire

//--- verilog/qcpu_regfile.sv
`default_nettype none

module qcpu_regfile (
	input  logic               clk,
	input  logic               rst_n,
	input  logic               we,
	input  qcpu_pkg::reg_sel_t wr_sel,
	input  qcpu_pkg::data_t    wr_data,
	input  logic               pair_we,
	input  logic [15:0]        pair_wdata,
	input  qcpu_pkg::reg_sel_t ra_sel,
	input  qcpu_pkg::reg_sel_t rb_sel,
	output qcpu_pkg::data_t    ra_data,
	output qcpu_pkg::data_t    rb_data,
	output logic [15:0]        pair_data
);
	import qcpu_pkg::*;

	data_t regs [1:15]; // R0 has no storage

	assign ra_data   = (ra_sel == '0) ? '0 : regs[ra_sel];
	assign rb_data   = (rb_sel == '0) ? '0 : regs[rb_sel];
	assign pair_data = {regs[2], regs[1]};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 1; i < 16; i++)
				regs[i] <= '0;
		end else if (pair_we) begin
			regs[1] <= pair_wdata[7:0];
			regs[2] <= pair_wdata[15:8];
		end else if (we && wr_sel != '0) begin
			regs[wr_sel] <= wr_data;
		end
	end

endmodule

`default_nettype wire

//--- verilog/qcpu_alu.sv
`default_nettype none

module qcpu_alu (
	input  qcpu_pkg::instr_t   instr,
	input  qcpu_pkg::data_t    ra_data,
	input  qcpu_pkg::data_t    rb_data,
	input  qcpu_pkg::data_t    r1_data,
	input  qcpu_pkg::data_t    io_rdata,
	input  logic               c_flag,
	input  logic               z_flag,
	input  qcpu_pkg::pc_t      link_pc,
	output qcpu_pkg::data_t    result,
	output qcpu_pkg::reg_sel_t wr_sel,
	output logic [15:0]        pair_result,
	output logic               c_next,
	output logic               z_next,
	output logic               flag_we
);
	import qcpu_pkg::*;

	data_t      nib;     // Zero-extended nibble field
	logic [8:0] rr_res;
	data_t      ext_res;

	assign nib = {4'h0, instr.regreg.r2};
	assign pair_result = (is_ext(instr) && instr.ext.op == ext_mul) ?
		r1_data * rb_data : {2'b00, link_pc};

	always_comb begin
		case (instr.regreg.op)
			alu_add:  rr_res = {1'b0, ra_data} + {1'b0, rb_data};
			alu_adc:  rr_res = {1'b0, ra_data} + {1'b0, rb_data} + c_flag;
			alu_sub:  rr_res = {1'b0, ra_data} + {1'b0, ~rb_data} + 9'd1;
			alu_sbc:  rr_res = {1'b0, ra_data} + {1'b0, ~rb_data} + c_flag;
			alu_and:  rr_res = {c_flag, ra_data & rb_data};
			alu_or:   rr_res = {c_flag, ra_data | rb_data};
			alu_xor:  rr_res = {c_flag, ra_data ^ rb_data};
			alu_not:  rr_res = {c_flag, ~rb_data};
			alu_addi: rr_res = {1'b0, ra_data} + {1'b0, nib};
			alu_adci: rr_res = {1'b0, ra_data} + {1'b0, nib} + c_flag;
			alu_subi: rr_res = {1'b0, ra_data} + {1'b0, ~nib} + 9'd1;
			alu_sbci: rr_res = {1'b0, ra_data} + {1'b0, ~nib} + c_flag;
			default:  rr_res = {c_flag, ra_data};
		endcase
	end

	always_comb begin
		case (instr.ext.op)
			ext_shr:  ext_res = {1'b0, rb_data[7:1]};
			ext_shrc: ext_res = {c_flag, rb_data[7:1]};
			ext_shl:  ext_res = {rb_data[6:0], 1'b0};
			ext_shlc: ext_res = {rb_data[6:0], c_flag};
			ext_ror:  ext_res = {rb_data[0], rb_data[7:1]};
			ext_rol:  ext_res = {rb_data[6:0], rb_data[7]};
			ext_getf: ext_res = {6'b0, z_flag, c_flag};
			default:  ext_res = io_rdata; // I/O read
		endcase
	end

	always_comb begin
		result  = rr_res[7:0];
		wr_sel  = instr.regreg.r1;
		c_next  = c_flag;
		z_next  = z_flag;
		flag_we = 1'b0;
		if (is_imm(instr)) begin
			result = instr.immediate.value;
			wr_sel = instr.immediate.rd;
		end else if (is_load(instr)) begin
			result = io_rdata; // RAM data on loads
			wr_sel = instr.loadstore.rd;
		end else if (is_ext(instr)) begin
			result = ext_res;
			wr_sel = instr.ext.rs;
			if (instr.ext.op inside {ext_shr, ext_shrc, ext_shl, ext_shlc, ext_ror, ext_rol}) begin
				z_next  = ext_res == '0;
				flag_we = 1'b1;
			end
			if (instr.ext.op inside {ext_shr, ext_shrc})
				c_next = rb_data[0];
			else if (instr.ext.op inside {ext_shl, ext_shlc})
				c_next = rb_data[7];
			else if (instr.ext.op == ext_cmpi) begin
				c_next  = r1_data >= nib;
				z_next  = r1_data == nib;
				flag_we = 1'b1;
			end
		end else if (is_regreg(instr)) begin
			if (instr.regreg.op == alu_cmp) begin
				c_next  = ra_data >= rb_data;
				z_next  = ra_data == rb_data;
				flag_we = 1'b1;
			end else if (!(instr.regreg.op inside {alu_link, alu_jmpi})) begin
				c_next  = rr_res[8];
				z_next  = rr_res[7:0] == '0;
				flag_we = 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

//--- verilog/qcpu_io.sv
`default_nettype none

module qcpu_io (
	input  logic             clk,
	input  logic             rst_n,
	input  qcpu_pkg::instr_t instr,
	input  logic             execute,
	input  qcpu_pkg::data_t  wdata,
	input  qcpu_pkg::data_t  pina,
	input  qcpu_pkg::data_t  pinb,
	input  logic             int_entry,
	input  logic             int_return,
	output qcpu_pkg::data_t  io_rdata,
	output qcpu_pkg::data_t  porta,
	output qcpu_pkg::data_t  portb,
	output qcpu_pkg::data_t  porta_ddr,
	output qcpu_pkg::data_t  portb_ddr
);
	import qcpu_pkg::*;

	data_t io_addr;
	data_t saved_addr;
	logic  imm_addr; // Immediate to R0 sets the address
	logic  set_addr;
	logic  io_write;

	assign imm_addr = execute && is_imm(instr) && instr.immediate.rd == '0;
	assign set_addr = execute && is_ext(instr) && instr.ext.op == ext_ioaddr;
	assign io_write = execute && is_ext(instr) && instr.ext.op == ext_iow;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			io_addr    <= '0;
			saved_addr <= '0;
			porta      <= '0;
			portb      <= '0;
			porta_ddr  <= '0;
			portb_ddr  <= '0;
		end else begin
			if (int_entry)
				saved_addr <= io_addr;
			if (int_return)
				io_addr <= saved_addr;
			else if (imm_addr)
				io_addr <= instr.immediate.value;
			else if (set_addr)
				io_addr <= wdata;
			if (io_write) begin
				case (io_addr)
					io_porta_ddr: porta_ddr <= wdata;
					io_porta:     porta     <= wdata;
					io_portb_ddr: portb_ddr <= wdata;
					io_portb:     portb     <= wdata;
					default: ; // Pin registers are read only
				endcase
			end
		end
	end

	always_comb begin
		case (io_addr)
			io_porta_ddr: io_rdata = porta_ddr;
			io_porta:     io_rdata = porta;
			io_portb_ddr: io_rdata = portb_ddr;
			io_portb:     io_rdata = portb;
			io_pina:      io_rdata = pina;
			io_pinb:      io_rdata = pinb;
			default:      io_rdata = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- verilog/qcpu_top.sv
`default_nettype none

module qcpu_top (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [15:0]         rom_data,
	input  qcpu_pkg::data_t     ram_rdata,
	input  qcpu_pkg::data_t     pina,
	input  qcpu_pkg::data_t     pinb,
	input  logic                intb,
	output qcpu_pkg::pc_t       rom_addr,
	output qcpu_pkg::ram_addr_t ram_addr,
	output qcpu_pkg::data_t     ram_wdata,
	output logic                ram_we,
	output qcpu_pkg::data_t     porta,
	output qcpu_pkg::data_t     portb,
	output qcpu_pkg::data_t     porta_ddr,
	output qcpu_pkg::data_t     portb_ddr
);
	import qcpu_pkg::*;

	instr_t      instr;
	cycle_e      state;
	logic        c_flag;
	logic        z_flag;
	logic        c_next;
	logic        z_next;
	logic        flag_we;
	logic        reg_we;
	logic        pair_we;
	logic        int_entry;
	logic        int_return;
	pc_t         link_pc;
	data_t       ra_data;
	data_t       rb_data;
	data_t       result;
	data_t       io_rdata;
	data_t       rd_data;
	reg_sel_t    wr_sel;
	logic [15:0] pair_data;
	logic [15:0] pair_result;

	assign ram_addr  = instr.loadstore.base + rb_data[ram_addr_w-1:0];
	assign ram_wdata = ra_data;
	assign rd_data   = is_load(instr) ? ram_rdata : io_rdata;

	qcpu_sequencer qcpu_sequencer_i (
		.clk(clk), .rst_n(rst_n), .intb(intb), .rom_data(rom_data),
		.c_next(c_next), .z_next(z_next), .flag_we(flag_we), .pair_data(pair_data),
		.rom_addr(rom_addr), .instr(instr), .state(state),
		.c_flag(c_flag), .z_flag(z_flag),
		.reg_we(reg_we), .pair_we(pair_we), .ram_we(ram_we), .link_pc(link_pc),
		.int_entry(int_entry), .int_return(int_return)
	);

	// r1 shares bits with the load/store destination, r2 with index and ext register
	qcpu_regfile qcpu_regfile_i (
		.clk(clk), .rst_n(rst_n), .we(reg_we), .wr_sel(wr_sel), .wr_data(result),
		.pair_we(pair_we), .pair_wdata(pair_result),
		.ra_sel(instr.regreg.r1), .rb_sel(instr.regreg.r2),
		.ra_data(ra_data), .rb_data(rb_data), .pair_data(pair_data)
	);

	qcpu_alu qcpu_alu_i (
		.instr(instr), .ra_data(ra_data), .rb_data(rb_data), .r1_data(pair_data[7:0]),
		.io_rdata(rd_data), .c_flag(c_flag), .z_flag(z_flag), .link_pc(link_pc),
		.result(result), .wr_sel(wr_sel), .pair_result(pair_result),
		.c_next(c_next), .z_next(z_next), .flag_we(flag_we)
	);

	qcpu_io qcpu_io_i (
		.clk(clk), .rst_n(rst_n), .instr(instr), .execute(state == cyc_execute),
		.wdata(rb_data), .pina(pina), .pinb(pinb),
		.int_entry(int_entry), .int_return(int_return),
		.io_rdata(io_rdata), .porta(porta), .portb(portb),
		.porta_ddr(porta_ddr), .portb_ddr(portb_ddr)
	);

endmodule

`default_nettype wire

//--- bench/qcpu_tb.sv
`default_nettype none

module qcpu_tb;
	timeunit 1ns;
	timeprecision 1ps;

	import qcpu_pkg::*;

	localparam int max_tests = 16;
	localparam int max_words = 1024;
	localparam int rom_depth = 256;

	logic        clk;
	logic        rst_n;
	logic [15:0] rom_data;
	data_t       ram_rdata;
	data_t       pina;
	data_t       pinb;
	logic        intb;
	pc_t         rom_addr;
	ram_addr_t   ram_addr;
	data_t       ram_wdata;
	logic        ram_we;
	data_t       porta;
	data_t       portb;
	data_t       porta_ddr;
	data_t       portb_ddr;

	logic [15:0]  rom [0:rom_depth-1];
	data_t        ram [0:63];
	logic [15:0]  words [0:max_words-1]; // ROM images of all tests, back to back
	logic [127:0] test_name [0:max_tests-1];
	int           test_start [0:max_tests-1];
	int           test_len [0:max_tests-1];
	int           test_int_cycle [0:max_tests-1];
	data_t        test_pina [0:max_tests-1];
	data_t        test_pinb [0:max_tests-1];
	data_t        test_porta [0:max_tests-1];
	data_t        test_portb [0:max_tests-1];
	data_t        test_ram_addr [0:max_tests-1];
	data_t        test_ram_data [0:max_tests-1];
	int           n_tests;
	int           n_words;
	int           cycle_limit;
	int           cycles = 0;
	int           passed;
	int           failed;

	qcpu_top qcpu_top_i (
		.clk(clk), .rst_n(rst_n), .rom_data(rom_data), .ram_rdata(ram_rdata),
		.pina(pina), .pinb(pinb), .intb(intb),
		.rom_addr(rom_addr), .ram_addr(ram_addr), .ram_wdata(ram_wdata), .ram_we(ram_we),
		.porta(porta), .portb(portb), .porta_ddr(porta_ddr), .portb_ddr(portb_ddr)
	);

	function automatic logic [15:0] rom_word(input pc_t a);
		if (a < rom_depth)
			return rom[a];
		return {2'b00, a}; // Jump to self outside the image
	endfunction

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// Synchronous ROM
	initial begin
		rom_data = '0;
		forever begin
			@(posedge clk);
			#5;
			rom_data = rom_word(rom_addr);
		end
	end

	assign ram_rdata = ram[ram_addr]; // Asynchronous read

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("Timeout: a test did not reach its final jump within %0d cycles", cycle_limit);
			$display("Done: errors found");
			$finish;
		end
	end

	task automatic read_tests(input int fd);
		logic [255:0]  tok;
		logic [2047:0] line;
		logic [127:0]  name;
		logic [15:0]   word;
		data_t         pa, pb, ea, eb, rad, rdat;
		int            icyc;
		int            cnt;
		int            r;
		n_tests = 0;
		n_words = 0;
		while (!$feof(fd)) begin
			tok = '0;
			r = $fscanf(fd, "%s", tok);
			if (r == 1) begin
				if (tok == "#") begin
					r = $fgets(line, fd);
				end else if (tok == "test") begin
					r = $fscanf(fd, "%s %h %h %d %h %h %h %h %d",
						name, pa, pb, icyc, ea, eb, rad, rdat, cnt);
					test_name[n_tests]      = name;
					test_pina[n_tests]      = pa;
					test_pinb[n_tests]      = pb;
					test_int_cycle[n_tests] = icyc;
					test_porta[n_tests]     = ea;
					test_portb[n_tests]     = eb;
					test_ram_addr[n_tests]  = rad;
					test_ram_data[n_tests]  = rdat;
					test_start[n_tests]     = n_words;
					test_len[n_tests]       = cnt;
					for (int k = 0; k < cnt; k++) begin
						r = $fscanf(fd, "%h", word);
						words[n_words] = word;
						n_words = n_words + 1;
					end
					n_tests = n_tests + 1;
				end
			end
		end
	endtask

	task automatic run_test(input int t);
		int   cyc;
		int   idle;
		logic bad;
		bad = 1'b0;
		@(posedge clk);
		#5;
		rst_n = 1'b0;
		intb  = 1'b1;
		pina  = test_pina[t];
		pinb  = test_pinb[t];
		for (int a = 0; a < rom_depth; a++)
			rom[a] = 16'(a);
		for (int a = 0; a < test_len[t]; a++)
			rom[a] = words[test_start[t] + a];
		for (int a = 0; a < 64; a++)
			ram[a] = 8'(a) ^ 8'ha5;
		repeat (2) @(posedge clk);
		#5;
		// Ports, direction registers and PC come out of reset cleared
		if (porta !== 8'h00 || portb !== 8'h00 || porta_ddr !== 8'h00 ||
			portb_ddr !== 8'h00 || ram_we !== 1'b0 || rom_addr !== 14'd0) begin
			bad = 1'b1;
			$display("FAIL %0t %0s: after reset porta %h portb %h ddr %h %h ram_we %b pc %h",
				$time, test_name[t], porta, portb, porta_ddr, portb_ddr, ram_we, rom_addr);
		end
		rst_n = 1'b1;
		cyc  = 0;
		idle = 0;
		// Ends once PC has sat on a jump to itself for more than one instruction
		while (idle < 4) begin
			@(posedge clk);
			#5;
			cyc = cyc + 1;
			if (cyc == test_int_cycle[t])
				intb = 1'b0;
			@(negedge clk);
			if (ram_we)
				ram[ram_addr] = ram_wdata;
			if (rom_word(rom_addr) == {2'b00, rom_addr})
				idle = idle + 1;
			else
				idle = 0;
		end
		if (porta !== test_porta[t])
			bad = 1'b1;
		if (portb !== test_portb[t])
			bad = 1'b1;
		if (test_ram_addr[t] != 8'hff && ram[test_ram_addr[t][5:0]] !== test_ram_data[t])
			bad = 1'b1;
		if (bad) begin
			failed = failed + 1;
			$display("FAIL %0t %0s: porta %h (exp %h), portb %h (exp %h), ram %h (exp %h)",
				$time, test_name[t], porta, test_porta[t], portb, test_portb[t],
				ram[test_ram_addr[t][5:0]], test_ram_data[t]);
		end else begin
			passed = passed + 1;
			$display("PASS %0s", test_name[t]);
		end
	endtask

	initial begin
		int fd;
		rst_n  = 1'b0;
		intb   = 1'b1;
		pina   = '0;
		pinb   = '0;
		passed = 0;
		failed = 0;
		fd = $fopen("bench/qcpu_tests.txt", "r");
		if (fd == 0) begin
			$display("Cannot open the test file bench/qcpu_tests.txt");
			$display("Done: errors found");
			$finish;
		end else begin
			read_tests(fd);
			$fclose(fd);
			cycle_limit = 3 * n_words * 4 + 20 * n_tests + 100;
			for (int t = 0; t < n_tests; t++)
				run_test(t);
			$display("Tests: %0d passed, %0d failed", passed, failed);
			if (failed == 0)
				$display("Done: no errors");
			else
				$display("Done: errors found");
			$finish;
		end
	end

endmodule

`default_nettype wire

//--- bench/qcpu_tests.txt
# test <name> <pina> <pinb> <int_cycle> <porta> <portb> <ram_addr> <ram_data> <count>, ROM words
# Hex values, int_cycle and count decimal; int_cycle 0 means no interrupt, ram_addr ff no RAM check
test alu 00 00 0 5d 7b ff 00 23
41c8 4250 5012 4370 5133 5231 5332 5413
5523 5612 5745 5847 5943 5a4b 5b42 5014
5fd5 5153 4001 5f71 4003 5f75 0016
test shift 00 00 0 85 05 ff 00 18
4181 5f01 5f11 5f21 5f31 5f41 5f51 4205
5fc2 4301 5f03 5fd4 5024 4001 5f71 4003
5f72 0011
# Wrong paths add to R5 and spoil port B
test branch 00 00 0 a5 1f ff 00 26
6002 5858 5851 6802 5852 7802 5854 7002
585f 4603 5858 5a61 77fe 6802 585f 7802
585f 5c00 0018 4001 5f77 4003 5f75 0017
47a5 5d00
test ram 00 00 0 33 44 0f 33 12
4133 4205 8a12 4344 8132 cf40 c152 4001
5f74 4003 5f75 000b
test ports 3c c3 0 2c 58 ff 00 27
4000 41f0 5f71 4002 420f 5f72 4000 5f83
4002 5f84 4004 5f85 4005 5f86 5035 5646
4001 5f73 4703 5f67 5f74 4001 5f88 5f67
5088 5f78 001a
# Handler at 1 changes flags and I/O address, main then relies on both
test irq 00 00 18 42 e7 ff 00 20
0006 4003 49e7 5f79 5f0a 5fb0 4105 5fe0
4001 4640 4811 4811 4811 4811 4811 4811
5fd5 5165 5f76 0013

//--- project.f
verilog/qcpu_pkg.sv
verilog/qcpu_sequencer.sv
verilog/qcpu_regfile.sv
verilog/qcpu_alu.sv
verilog/qcpu_io.sv
verilog/qcpu_top.sv
bench/qcpu_tb.sv

//--- Bender.yml
package:
  name: qcpu

sources:
  - verilog/qcpu_pkg.sv
  - verilog/qcpu_sequencer.sv
  - verilog/qcpu_regfile.sv
  - verilog/qcpu_alu.sv
  - verilog/qcpu_io.sv
  - verilog/qcpu_top.sv
  - target: test
    files:
      - bench/qcpu_tb.sv
